/* source/cpu_pkg.sv */
package cpu_pkg;

// ------------------------------
// Data widths
// ------------------------------

typedef logic [15:0] word_t;     // Register or ALU value
typedef logic [7:0]  byte_t;     // Code byte or port byte
typedef logic [15:0] addr_t;     // Code address or port number
typedef logic [11:0] flags_t;    // 8086 flags word, upper nibble unused
typedef logic [2:0]  reg_idx_t;  // Register field of opcode or ModRM

// ------------------------------
// Flag positions
// ------------------------------

localparam int CF_BIT = 0;
localparam int PF_BIT = 2;
localparam int AF_BIT = 4;
localparam int ZF_BIT = 6;
localparam int SF_BIT = 7;
localparam int TF_BIT = 8;
localparam int IF_BIT = 9;
localparam int OF_BIT = 11;

// ------------------------------
// Register indices
// ------------------------------

// Word view; in byte form 0..3 are AL..BL and 4..7 are AH..BH
localparam reg_idx_t REG_AX = 3'd0;
localparam reg_idx_t REG_CX = 3'd1;
localparam reg_idx_t REG_DX = 3'd2;
localparam reg_idx_t REG_BX = 3'd3;
localparam reg_idx_t REG_SP = 3'd4;
localparam reg_idx_t REG_BP = 3'd5;
localparam reg_idx_t REG_SI = 3'd6;
localparam reg_idx_t REG_DI = 3'd7;

// ALU operation, same order as bits 5:3 of the x86 ALU opcodes
typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_OR  = 3'd1,
    ALU_ADC = 3'd2,
    ALU_SBB = 3'd3,
    ALU_AND = 3'd4,
    ALU_SUB = 3'd5,
    ALU_XOR = 3'd6,
    ALU_CMP = 3'd7
} alu_op_t;

endpackage

/* source/cpu_alu.sv */
module cpu_alu (
    input  cpu_pkg::alu_op_t i_op,
    input  logic             i_word,     // 1 = 16 bit, 0 = 8 bit
    input  cpu_pkg::word_t   i_a,
    input  cpu_pkg::word_t   i_b,
    input  cpu_pkg::flags_t  i_flags,
    output cpu_pkg::word_t   o_result,
    output cpu_pkg::flags_t  o_flags
);

cpu_pkg::word_t a;
cpu_pkg::word_t b;
cpu_pkg::word_t res;
logic [16:0]    r;       // Raw result with carry out above the top bit
logic           carry_in;
logic           top_a;
logic           top_b;
logic           top_r;

// Byte mode works on the low halves only
assign a = i_word ? i_a : {8'h00, i_a[7:0]};
assign b = i_word ? i_b : {8'h00, i_b[7:0]};
assign carry_in = i_flags[cpu_pkg::CF_BIT];

always_comb begin
    case (i_op)
        cpu_pkg::ALU_ADD: r = {1'b0, a} + {1'b0, b};
        cpu_pkg::ALU_ADC: r = {1'b0, a} + {1'b0, b} + 17'(carry_in);
        cpu_pkg::ALU_SBB: r = {1'b0, a} - {1'b0, b} - 17'(carry_in);
        cpu_pkg::ALU_SUB,
        cpu_pkg::ALU_CMP: r = {1'b0, a} - {1'b0, b};
        cpu_pkg::ALU_OR:  r = {1'b0, a | b};
        cpu_pkg::ALU_AND: r = {1'b0, a & b};
        default:          r = {1'b0, a ^ b};  // XOR
    endcase
end

assign res   = i_word ? r[15:0] : {8'h00, r[7:0]};
assign top_a = i_word ? a[15] : a[7];
assign top_b = i_word ? b[15] : b[7];
assign top_r = i_word ? r[15] : r[7];

// ------------------------------
// Flags
// ------------------------------

always_comb begin
    o_flags = i_flags;   // TF, IF, DF and bit 1 pass through

    o_flags[cpu_pkg::CF_BIT] = i_word ? r[16] : r[8];
    o_flags[cpu_pkg::AF_BIT] = a[4] ^ b[4] ^ r[4];

    case (i_op)
        cpu_pkg::ALU_ADD,
        cpu_pkg::ALU_ADC: o_flags[cpu_pkg::OF_BIT] = ~(top_a ^ top_b) & (top_a ^ top_r);
        cpu_pkg::ALU_SUB,
        cpu_pkg::ALU_SBB,
        cpu_pkg::ALU_CMP: o_flags[cpu_pkg::OF_BIT] = (top_a ^ top_b) & (top_a ^ top_r);
        default: begin
            // Logic ops
            o_flags[cpu_pkg::OF_BIT] = 1'b0;
            o_flags[cpu_pkg::CF_BIT] = 1'b0;
            o_flags[cpu_pkg::AF_BIT] = r[4];
        end
    endcase

    o_flags[cpu_pkg::SF_BIT] = top_r;
    o_flags[cpu_pkg::ZF_BIT] = (res == 16'h0000);
    o_flags[cpu_pkg::PF_BIT] = ~^r[7:0];  // Parity of low byte only
end

assign o_result = res;

// The op register in control is reset, so a bad code means a broken decode path
always_comb begin
    assert final (!$isunknown(i_op))
        else $error("ALU operation code is unknown");
end

endmodule

/* source/cpu_regs.sv */
module cpu_regs (
    input  logic              clock,
    input  logic              i_arst_n,

    // Two read ports, shared width select
    input  cpu_pkg::reg_idx_t i_rd_a_idx,
    input  cpu_pkg::reg_idx_t i_rd_b_idx,
    input  logic              i_rd_word,
    output cpu_pkg::word_t    o_rd_a,
    output cpu_pkg::word_t    o_rd_b,

    // Write port
    input  logic              i_wr_en,
    input  cpu_pkg::reg_idx_t i_wr_idx,
    input  logic              i_wr_word,
    input  cpu_pkg::word_t    i_wr_data,

    // Flags
    input  logic              i_flags_wr,
    input  cpu_pkg::flags_t   i_flags,
    output cpu_pkg::flags_t   o_flags
);

cpu_pkg::word_t  regs [8];
cpu_pkg::flags_t flags_q;

// Byte indices 4..7 select the high half of AX..BX
function automatic cpu_pkg::word_t read_reg(cpu_pkg::reg_idx_t idx, logic word);
    cpu_pkg::word_t pair;
    pair = regs[{1'b0, idx[1:0]}];
    if (word)
        return regs[idx];
    return idx[2] ? {8'h00, pair[15:8]} : {8'h00, pair[7:0]};
endfunction

always_comb begin
    o_rd_a = read_reg(i_rd_a_idx, i_rd_word);
    o_rd_b = read_reg(i_rd_b_idx, i_rd_word);
end

always_ff @(posedge clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
        for (int i = 0; i < 8; i++)
            regs[i] <= '0;
        flags_q <= '0;
    end else begin
        if (i_wr_en) begin
            if (i_wr_word)
                regs[i_wr_idx] <= i_wr_data;
            else if (i_wr_idx[2])
                regs[{1'b0, i_wr_idx[1:0]}][15:8] <= i_wr_data[7:0];  // AH..BH
            else
                regs[{1'b0, i_wr_idx[1:0]}][7:0] <= i_wr_data[7:0];   // AL..BL
        end
        if (i_flags_wr)
            flags_q <= i_flags;
    end
end

always_comb begin
    o_flags = flags_q;
    o_flags[1] = 1'b1;                 // Always set on the 8086
    o_flags[cpu_pkg::TF_BIT] = 1'b0;   // No trap or interrupt logic
    o_flags[cpu_pkg::IF_BIT] = 1'b0;
end

a_wr_idx_known: assert property (@(posedge clock) disable iff (!i_arst_n)
    i_wr_en |-> !$isunknown(i_wr_idx))
    else $error("Register write with unknown index");

endmodule

/* source/cpu_control.sv */
module cpu_control #(
    parameter cpu_pkg::addr_t RESET_IP = 16'h0000
) (
    input  logic              clock,
    input  logic              i_arst_n,

    // Code memory, asynchronous read
    output cpu_pkg::addr_t    o_code_addr,
    input  cpu_pkg::byte_t    i_code_data,

    // Register file
    output cpu_pkg::reg_idx_t o_rd_a_idx,
    output cpu_pkg::reg_idx_t o_rd_b_idx,
    output logic              o_rd_word,
    input  cpu_pkg::word_t    i_rd_a,
    input  cpu_pkg::word_t    i_rd_b,

    // ALU
    output cpu_pkg::alu_op_t  o_alu_op,
    output logic              o_alu_word,
    output cpu_pkg::word_t    o_alu_a,
    output cpu_pkg::word_t    o_alu_b,
    input  cpu_pkg::word_t    i_alu_result,
    input  cpu_pkg::flags_t   i_alu_flags,

    // Write back
    output logic              o_wr_en,
    output cpu_pkg::reg_idx_t o_wr_idx,
    output logic              o_wr_word,
    output cpu_pkg::word_t    o_wr_data,
    output logic              o_flags_wr,
    output cpu_pkg::flags_t   o_flags,
    input  cpu_pkg::flags_t   i_flags,

    // Port output
    output cpu_pkg::addr_t    o_port_addr,
    output cpu_pkg::byte_t    o_port_data,
    output logic              o_port_write,
    output logic              o_halted
);

typedef enum logic [2:0] {
    FETCH,
    MODRM,
    IMM_LO,
    IMM_HI,
    EXEC,
    OUT_HI,
    HALT
} state_t;

state_t            state;
cpu_pkg::addr_t    ip;
cpu_pkg::byte_t    opcode;
cpu_pkg::reg_idx_t dst_idx;
logic              op_word;
cpu_pkg::alu_op_t  alu_op;
cpu_pkg::word_t    alu_a;
cpu_pkg::word_t    alu_b;
cpu_pkg::addr_t    port_addr;
cpu_pkg::byte_t    port_data;
logic              port_write;
cpu_pkg::word_t    disp;        // Sign extended rel8
logic [7:0]        branches;
logic              cond_true;

assign disp = {{8{i_code_data[7]}}, i_code_data};

// Jcc condition table, indexed by opcode[3:1], opcode[0] inverts
assign branches = {
    (i_flags[cpu_pkg::SF_BIT] ^ i_flags[cpu_pkg::OF_BIT]) | i_flags[cpu_pkg::ZF_BIT],  // LE
    i_flags[cpu_pkg::SF_BIT] ^ i_flags[cpu_pkg::OF_BIT],                               // L
    i_flags[cpu_pkg::PF_BIT],
    i_flags[cpu_pkg::SF_BIT],
    i_flags[cpu_pkg::CF_BIT] | i_flags[cpu_pkg::ZF_BIT],                               // BE
    i_flags[cpu_pkg::ZF_BIT],
    i_flags[cpu_pkg::CF_BIT],
    i_flags[cpu_pkg::OF_BIT]
};
assign cond_true = branches[opcode[3:1]] ^ opcode[0];

// ------------------------------
// Register read select
// ------------------------------

always_comb begin
    o_rd_a_idx = cpu_pkg::REG_AX;
    o_rd_b_idx = i_code_data[5:3];
    o_rd_word  = 1'b1;
    case (state)
        FETCH:  o_rd_a_idx = i_code_data[2:0];  // INC/DEC operand
        MODRM: begin
            // d bit picks which field is the destination
            o_rd_a_idx = opcode[1] ? i_code_data[5:3] : i_code_data[2:0];
            o_rd_b_idx = opcode[1] ? i_code_data[2:0] : i_code_data[5:3];
            o_rd_word  = opcode[0];
        end
        IMM_LO: o_rd_word = opcode[0];          // AL or AX
        default: ;
    endcase
end

// ------------------------------
// Sequencer
// ------------------------------

always_ff @(posedge clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
        state      <= FETCH;
        ip         <= RESET_IP;
        opcode     <= '0;
        dst_idx    <= '0;
        op_word    <= 1'b0;
        alu_op     <= cpu_pkg::ALU_ADD;
        port_write <= 1'b0;
    end else begin
        port_write <= 1'b0;
        case (state)
            FETCH: begin
                opcode  <= i_code_data;
                ip      <= ip + 16'd1;
                op_word <= 1'b1;
                dst_idx <= i_code_data[2:0];
                alu_op  <= cpu_pkg::alu_op_t'(i_code_data[5:3]);
                casez (i_code_data)
                    8'b00???0??: begin  // ALU r/m, r
                        state   <= MODRM;
                        op_word <= i_code_data[0];
                    end
                    8'b00???10?: begin  // ALU acc, imm
                        state   <= IMM_LO;
                        op_word <= i_code_data[0];
                        dst_idx <= cpu_pkg::REG_AX;
                    end
                    8'b1011????: begin  // MOV r, imm
                        state   <= IMM_LO;
                        op_word <= i_code_data[3];
                    end
                    8'b0100????: begin  // INC/DEC r16
                        state  <= EXEC;
                        alu_op <= i_code_data[3] ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
                    end
                    8'b0111????,
                    8'hEB,
                    8'hE6,
                    8'hE7:   state <= IMM_LO;
                    8'hF5,
                    8'hF8,
                    8'hF9:   state <= EXEC;   // CMC, CLC, STC
                    8'hF4:   state <= HALT;
                    default: state <= FETCH;  // Anything else is a one-byte no-op
                endcase
            end
            MODRM: begin
                if (i_code_data[7:6] == 2'b11) begin
                    ip      <= ip + 16'd1;
                    dst_idx <= o_rd_a_idx;
                    state   <= EXEC;
                end else begin
                    state <= FETCH;  // Memory form, leave the byte unread
                end
            end
            IMM_LO: begin
                ip <= ip + 16'd1;
                casez (opcode)
                    8'b0111????: begin
                        if (cond_true)
                            ip <= ip + 16'd1 + disp;
                        state <= FETCH;
                    end
                    8'hEB: begin
                        ip    <= ip + 16'd1 + disp;
                        state <= FETCH;
                    end
                    8'hE6,
                    8'hE7: begin
                        port_write <= 1'b1;
                        state      <= opcode[0] ? OUT_HI : FETCH;
                    end
                    default: state <= op_word ? IMM_HI : EXEC;
                endcase
            end
            IMM_HI: begin
                ip    <= ip + 16'd1;
                state <= EXEC;
            end
            OUT_HI: begin
                port_write <= 1'b1;  // AH to the same port
                state      <= FETCH;
            end
            EXEC:    state <= FETCH;
            default: state <= HALT;  // Left only by reset
        endcase
    end
end

// Operands and port payload
always_ff @(posedge clock) begin
    case (state)
        FETCH: begin
            alu_a <= i_rd_a;
            alu_b <= 16'h0001;
        end
        MODRM: begin
            alu_a <= i_rd_a;
            alu_b <= i_rd_b;
        end
        IMM_LO: begin
            alu_a     <= i_rd_a;
            alu_b     <= {8'h00, i_code_data};
            port_addr <= {8'h00, i_code_data};
            port_data <= i_rd_a[7:0];
        end
        IMM_HI: alu_b[15:8] <= i_code_data;
        OUT_HI: port_data   <= i_rd_a[15:8];
        default: ;
    endcase
end

// ------------------------------
// Write back in EXEC
// ------------------------------

always_comb begin
    o_wr_en    = 1'b0;
    o_wr_data  = i_alu_result;
    o_flags_wr = 1'b0;
    o_flags    = i_alu_flags;
    if (state == EXEC) begin
        casez (opcode)
            8'b00??????: begin
                o_flags_wr = 1'b1;
                o_wr_en    = (alu_op != cpu_pkg::ALU_CMP);
            end
            8'b1011????: begin
                o_wr_en   = 1'b1;
                o_wr_data = alu_b;
            end
            8'b0100????: begin
                o_wr_en    = 1'b1;
                o_flags_wr = 1'b1;
                o_flags[cpu_pkg::CF_BIT] = i_flags[cpu_pkg::CF_BIT];  // INC/DEC keep CF
            end
            8'hF5: begin
                o_flags_wr = 1'b1;
                o_flags    = i_flags;
                o_flags[cpu_pkg::CF_BIT] = ~i_flags[cpu_pkg::CF_BIT];
            end
            8'hF8,
            8'hF9: begin
                o_flags_wr = 1'b1;
                o_flags    = i_flags;
                o_flags[cpu_pkg::CF_BIT] = opcode[0];
            end
            default: ;
        endcase
    end
end

assign o_code_addr  = ip;
assign o_alu_op     = alu_op;
assign o_alu_word   = op_word;
assign o_alu_a      = alu_a;
assign o_alu_b      = alu_b;
assign o_wr_idx     = dst_idx;
assign o_wr_word    = op_word;
assign o_port_addr  = port_addr;
assign o_port_data  = port_data;
assign o_port_write = port_write;
assign o_halted     = (state == HALT);

a_no_strobe_in_halt: assert property (@(posedge clock) disable iff (!i_arst_n)
    (state == HALT) |-> !o_port_write)
    else $error("Port strobe while halted");

a_modrm_register: assert property (@(posedge clock) disable iff (!i_arst_n)
    (state == MODRM) |-> (i_code_data[7:6] == 2'b11))
    else $error("ModRM with memory operand, executed as no-op");

endmodule

/* source/cpu_top.sv */
module cpu_top #(
    parameter cpu_pkg::addr_t RESET_IP = 16'h0000
) (
    input  logic           clock,
    input  logic           i_arst_n,
    output cpu_pkg::addr_t o_code_addr,
    input  cpu_pkg::byte_t i_code_data,
    output cpu_pkg::addr_t o_port_addr,
    output cpu_pkg::byte_t o_port_data,
    output logic           o_port_write,
    output logic           o_halted
);

cpu_pkg::reg_idx_t rd_a_idx;
cpu_pkg::reg_idx_t rd_b_idx;
logic              rd_word;
cpu_pkg::word_t    rd_a;
cpu_pkg::word_t    rd_b;
cpu_pkg::alu_op_t  alu_op;
logic              alu_word;
cpu_pkg::word_t    alu_a;
cpu_pkg::word_t    alu_b;
cpu_pkg::word_t    alu_result;
cpu_pkg::flags_t   alu_flags;
logic              wr_en;
cpu_pkg::reg_idx_t wr_idx;
logic              wr_word;
cpu_pkg::word_t    wr_data;
logic              flags_wr;
cpu_pkg::flags_t   flags_new;
cpu_pkg::flags_t   flags;   // Current flags from the register block

cpu_control #(
    .RESET_IP (RESET_IP)
) cpu_control_i (
    .clock        (clock),
    .i_arst_n     (i_arst_n),
    .o_code_addr  (o_code_addr),
    .i_code_data  (i_code_data),
    .o_rd_a_idx   (rd_a_idx),
    .o_rd_b_idx   (rd_b_idx),
    .o_rd_word    (rd_word),
    .i_rd_a       (rd_a),
    .i_rd_b       (rd_b),
    .o_alu_op     (alu_op),
    .o_alu_word   (alu_word),
    .o_alu_a      (alu_a),
    .o_alu_b      (alu_b),
    .i_alu_result (alu_result),
    .i_alu_flags  (alu_flags),
    .o_wr_en      (wr_en),
    .o_wr_idx     (wr_idx),
    .o_wr_word    (wr_word),
    .o_wr_data    (wr_data),
    .o_flags_wr   (flags_wr),
    .o_flags      (flags_new),
    .i_flags      (flags),
    .o_port_addr  (o_port_addr),
    .o_port_data  (o_port_data),
    .o_port_write (o_port_write),
    .o_halted     (o_halted)
);

cpu_regs cpu_regs_i (
    .clock      (clock),
    .i_arst_n   (i_arst_n),
    .i_rd_a_idx (rd_a_idx),
    .i_rd_b_idx (rd_b_idx),
    .i_rd_word  (rd_word),
    .o_rd_a     (rd_a),
    .o_rd_b     (rd_b),
    .i_wr_en    (wr_en),
    .i_wr_idx   (wr_idx),
    .i_wr_word  (wr_word),
    .i_wr_data  (wr_data),
    .i_flags_wr (flags_wr),
    .i_flags    (flags_new),
    .o_flags    (flags)
);

cpu_alu cpu_alu_i (
    .i_op     (alu_op),
    .i_word   (alu_word),
    .i_a      (alu_a),
    .i_b      (alu_b),
    .i_flags  (flags),
    .o_result (alu_result),
    .o_flags  (alu_flags)
);

endmodule

/* sim/cpu_tb.sv */
module cpu_tb;

localparam cpu_pkg::addr_t START_IP = 16'h0000;

logic           clock;
logic           i_arst_n;
cpu_pkg::addr_t o_code_addr;
cpu_pkg::byte_t i_code_data;
cpu_pkg::addr_t o_port_addr;
cpu_pkg::byte_t o_port_data;
logic           o_port_write;
logic           o_halted;

cpu_pkg::byte_t code_mem [65536];   // Full 64K code space
cpu_pkg::addr_t gen_pc;
int             n_instr;
integer         seed;

// Reference machine state
cpu_pkg::word_t ref_regs [8];
logic           f_cf;
logic           f_pf;
logic           f_zf;
logic           f_sf;
logic           f_of;
cpu_pkg::addr_t halt_ip;
logic [23:0]    exp_q [$];          // {port, data} in strobe order
logic [23:0]    exp_item;

int value_errors = 0;
int other_errors = 0;
int limit;
int cycles;

cpu_top #(
    .RESET_IP (START_IP)
) cpu_top_i (
    .clock        (clock),
    .i_arst_n     (i_arst_n),
    .o_code_addr  (o_code_addr),
    .i_code_data  (i_code_data),
    .o_port_addr  (o_port_addr),
    .o_port_data  (o_port_data),
    .o_port_write (o_port_write),
    .o_halted     (o_halted)
);

assign i_code_data = code_mem[o_code_addr];  // Asynchronous read

initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
end

// ------------------------------
// Program generation
// ------------------------------

function automatic logic [31:0] next_rand();
    next_rand = $random(seed);
endfunction

task automatic emit_byte(input cpu_pkg::byte_t b);
    code_mem[gen_pc] = b;
    gen_pc = gen_pc + 16'd1;
endtask

task automatic add_op(input cpu_pkg::byte_t op);
    emit_byte(op);
    n_instr++;
endtask

// Opcode plus one ModRM or imm8 byte
task automatic add_op_b(input cpu_pkg::byte_t op, input cpu_pkg::byte_t b);
    add_op(op);
    emit_byte(b);
endtask

task automatic add_op_w(input cpu_pkg::byte_t op, input cpu_pkg::word_t w);
    add_op(op);
    emit_byte(w[7:0]);
    emit_byte(w[15:8]);
endtask

task automatic build_program();
    logic [31:0] r;
    logic [31:0] q;
    logic [1:0]  low;
    gen_pc = START_IP;
    n_instr = 0;
    for (int round = 0; round < 8; round++) begin
        // Word ALU AX,BX then OUT 10h,AX
        r = next_rand();
        q = next_rand();
        add_op_w(8'hB8, r[15:0]);
        add_op_w(8'hBB, q[20] ? r[15:0] : r[31:16]);  // Equal operands now and then
        add_op_b({2'b00, q[2:0], 3'b011}, 8'hC3);
        add_op_b(8'hE7, 8'h10);

        // Byte ALU AL,imm8
        r = next_rand();
        add_op_b(8'hB0, r[7:0]);
        add_op_b({2'b00, r[10:8], 3'b100}, r[12] ? r[7:0] : r[23:16]);
        add_op_b(8'hE6, 8'h11);

        // Flags through a random Jcc
        r = next_rand();
        q = next_rand();
        add_op_w(8'hB8, r[15:0]);
        add_op_w({2'b00, r[18:16], 3'b101}, q[24] ? r[15:0] : q[15:0]);
        add_op_b(8'hB0, 8'h00);
        add_op_b({4'h7, r[23:20]}, 8'h02);   // Over MOV AL,1
        add_op_b(8'hB0, 8'h01);
        add_op_b(8'hE6, 8'h12);

        // INC from FFFCh..FFFFh or DEC from 0000h..0003h with CF held
        r = next_rand();
        low = (round == 0) ? {2{~r[4]}} : r[2:1];  // First round always wraps
        add_op_w(8'hB9, r[4] ? {14'h0000, low} : {14'h3FFF, low});
        add_op(r[3] ? 8'hF9 : 8'hF8);
        add_op(r[4] ? 8'h49 : 8'h41);
        add_op_b(8'hB0, 8'h00);
        add_op_b(8'h72, 8'h02);
        add_op_b(8'hB0, 8'h01);              // Marker skipped when carry set
        add_op_b(8'hE6, 8'h13);
        add_op_w(8'hB8, 16'h0000);
        add_op_b(8'h0B, 8'hC1);              // OR AX,CX
        add_op_b(8'hE7, 8'h14);

        // CMC then JMP short over a strobe
        add_op(8'hF5);
        add_op_b(8'hB0, 8'h00);
        add_op_b(8'h72, 8'h02);
        add_op_b(8'hB0, 8'h01);
        add_op_b(8'hEB, 8'h02);
        add_op_b(8'hE6, 8'h15);              // Never executed
        add_op_b(8'hE6, 8'h16);
    end
    add_op(8'hF4);
endtask

// ------------------------------
// Reference model
// ------------------------------

function automatic cpu_pkg::word_t read_ref(logic [2:0] idx, logic w);
    if (w)
        return ref_regs[idx];
    else if (idx[2])
        return {8'h00, ref_regs[{1'b0, idx[1:0]}][15:8]};
    else
        return {8'h00, ref_regs[{1'b0, idx[1:0]}][7:0]};
endfunction

function automatic void write_ref(logic [2:0] idx, logic w, cpu_pkg::word_t v);
    if (w)
        ref_regs[idx] = v;
    else if (idx[2])
        ref_regs[{1'b0, idx[1:0]}][15:8] = v[7:0];
    else
        ref_regs[{1'b0, idx[1:0]}][7:0] = v[7:0];
endfunction

// x86 ALU rules with op in ADD OR ADC SBB AND SUB XOR CMP order
function automatic cpu_pkg::word_t alu_model(logic [2:0] op, logic w, cpu_pkg::word_t a,
                                             cpu_pkg::word_t b);
    logic [31:0]    x;
    logic [31:0]    y;
    logic [31:0]    s;
    logic [31:0]    cin;
    cpu_pkg::word_t res;
    logic           sx;
    logic           sy;
    logic           sr;
    x = w ? {16'h0000, a} : {24'h000000, a[7:0]};
    y = w ? {16'h0000, b} : {24'h000000, b[7:0]};
    cin = {31'd0, f_cf};
    case (op)
        3'd0:    s = x + y;
        3'd1:    s = x | y;
        3'd2:    s = x + y + cin;
        3'd3:    s = x - y - cin;
        3'd4:    s = x & y;
        3'd6:    s = x ^ y;
        default: s = x - y;                  // SUB and CMP
    endcase
    res = w ? s[15:0] : {8'h00, s[7:0]};
    sx = w ? x[15] : x[7];
    sy = w ? y[15] : y[7];
    sr = w ? s[15] : s[7];
    f_zf = (res == 16'h0000);
    f_sf = sr;
    f_pf = ~^s[7:0];
    if (op == 3'd1 || op == 3'd4 || op == 3'd6) begin
        f_cf = 1'b0;
        f_of = 1'b0;
    end else begin
        f_cf = w ? s[16] : s[8];             // Borrow wraps into the upper bits
        if (op == 3'd0 || op == 3'd2)
            f_of = (sx == sy) && (sr != sx);
        else
            f_of = (sx != sy) && (sr != sx);
    end
    return res;
endfunction

function automatic logic jcc_taken(logic [3:0] cc);
    logic t;
    case (cc[3:1])
        3'd0:    t = f_of;
        3'd1:    t = f_cf;
        3'd2:    t = f_zf;
        3'd3:    t = f_cf | f_zf;
        3'd4:    t = f_sf;
        3'd5:    t = f_pf;
        3'd6:    t = f_sf ^ f_of;
        default: t = (f_sf ^ f_of) | f_zf;
    endcase
    return t ^ cc[0];                        // Odd codes are the negated forms
endfunction

// Runs the program from START_IP to HLT and queues every port write
function automatic void run_reference();
    cpu_pkg::addr_t pc;
    cpu_pkg::byte_t op;
    cpu_pkg::byte_t b1;
    cpu_pkg::byte_t b2;
    cpu_pkg::word_t res;
    logic [2:0]     dst;
    logic [2:0]     src;
    logic           keep_cf;
    logic           done;
    int             steps;
    ref_regs = '{default: 16'h0000};
    {f_cf, f_pf, f_zf, f_sf, f_of} = 5'b00000;
    pc = START_IP;
    done = 1'b0;
    steps = 0;
    while (!done && steps < 100000) begin
        op = code_mem[pc];
        b1 = code_mem[pc + 16'd1];
        b2 = code_mem[pc + 16'd2];
        steps++;
        casez (op)
            8'b00???0??: begin
                if (b1[7:6] != 2'b11) begin
                    pc = pc + 16'd1;         // Memory form is a no-op
                end else begin
                    dst = op[1] ? b1[5:3] : b1[2:0];
                    src = op[1] ? b1[2:0] : b1[5:3];
                    res = alu_model(op[5:3], op[0], read_ref(dst, op[0]), read_ref(src, op[0]));
                    if (op[5:3] != 3'd7)
                        write_ref(dst, op[0], res);
                    pc = pc + 16'd2;
                end
            end
            8'b00???10?: begin
                res = alu_model(op[5:3], op[0], read_ref(3'd0, op[0]),
                                op[0] ? {b2, b1} : {8'h00, b1});
                if (op[5:3] != 3'd7)
                    write_ref(3'd0, op[0], res);
                pc = pc + (op[0] ? 16'd3 : 16'd2);
            end
            8'b1011????: begin
                write_ref(op[2:0], op[3], op[3] ? {b2, b1} : {8'h00, b1});
                pc = pc + (op[3] ? 16'd3 : 16'd2);
            end
            8'b0100????: begin
                keep_cf = f_cf;
                res = alu_model(op[3] ? 3'd5 : 3'd0, 1'b1, read_ref(op[2:0], 1'b1), 16'h0001);
                f_cf = keep_cf;
                write_ref(op[2:0], 1'b1, res);
                pc = pc + 16'd1;
            end
            8'b0111????: begin
                pc = pc + 16'd2;
                if (jcc_taken(op[3:0]))
                    pc = pc + {{8{b1[7]}}, b1};
            end
            8'hEB: pc = pc + 16'd2 + {{8{b1[7]}}, b1};
            8'hE6,
            8'hE7: begin
                exp_q.push_back({8'h00, b1, ref_regs[3'd0][7:0]});
                if (op[0])
                    exp_q.push_back({8'h00, b1, ref_regs[3'd0][15:8]});  // AH second
                pc = pc + 16'd2;
            end
            8'hF5: begin
                f_cf = ~f_cf;
                pc = pc + 16'd1;
            end
            8'hF8,
            8'hF9: begin
                f_cf = op[0];
                pc = pc + 16'd1;
            end
            8'hF4: begin
                halt_ip = pc + 16'd1;        // IP moves past HLT
                done    = 1'b1;
            end
            default: pc = pc + 16'd1;
        endcase
    end
endfunction

// ------------------------------
// Port write checker
// ------------------------------

always @(negedge clock) begin
    if (i_arst_n && o_port_write) begin
        assert (!o_halted) else begin
            other_errors++;
            $display("Port write seen after the core halted");
        end
        assert (exp_q.size() > 0) else begin
            other_errors++;
            $display("Unexpected port write to %h with data %h", o_port_addr, o_port_data);
        end
        if (!o_halted && exp_q.size() > 0) begin
            exp_item = exp_q.pop_front();
            assert (o_port_addr == exp_item[23:8]) else begin
                value_errors++;
                $display("** Error o_port_addr: got %h expected %h", o_port_addr,
                         exp_item[23:8]);
            end
            assert (o_port_data == exp_item[7:0]) else begin
                value_errors++;
                $display("** Error o_port_data: got %h expected %h (port %h)", o_port_data,
                         exp_item[7:0], exp_item[23:8]);
            end
        end
    end
end

initial begin
    i_arst_n = 1'b0;
    seed = 32'hb96f;
    build_program();
    run_reference();
    limit = 40 * n_instr + 100;
    repeat (3) @(posedge clock);
    #1 i_arst_n = 1'b1;

    cycles = 0;
    while (!o_halted && cycles < limit) begin
        @(negedge clock);
        cycles++;
    end
    assert (o_halted) else begin
        other_errors++;
        $display("Timeout: core did not halt within %0d cycles", limit);
    end
    if (o_halted) begin
        assert (exp_q.size() == 0) else begin
            other_errors++;
            $display("Core halted with %0d expected port writes missing", exp_q.size());
        end
        assert (o_code_addr == halt_ip) else begin
            value_errors++;
            $display("** Error o_code_addr: got %h expected %h", o_code_addr, halt_ip);
        end
        repeat (16) @(negedge clock);   // Stray strobes after HLT
    end

    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0)
        $display("sim passed");
    else
        $display("sim failed");
    $finish;
end

endmodule

/* sim.f */
source/cpu_pkg.sv
source/cpu_alu.sv
source/cpu_regs.sv
source/cpu_control.sv
source/cpu_top.sv
sim/cpu_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := cpu_tb
FILELIST  := sim.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)
